/* lsu_macros.svh */
// lsu constants
// data width, data RAM depth in words and RAM access latency

`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// data and address width
`define LSU_XLEN        32

// number of 32-bit words in the data RAM
`define LSU_DM_DEPTH    256

// cycles from req rise to ack pulse, 1 or more
`define LSU_DM_LATENCY  2

`endif

/* lsu_pkg.sv */
// lsu types
// access size encoding and data-memory byte address

`include "lsu_macros.svh"

package lsu_pkg;

    // access size, same encoding as the funct3 low bits
    typedef enum logic [1:0]
    {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } lsu_size_t;

    // byte address into data memory
    typedef logic [`LSU_XLEN-1:0] dm_addr_t;

endpackage : lsu_pkg

/* dm_if.sv */
// data-memory bus
// request from the issue side, ack pulse and read data from the RAM

`timescale 1ns/1ns

`include "lsu_macros.svh"

interface dm_if;

    lsu_pkg::dm_addr_t      addr;   // byte address
    logic [`LSU_XLEN-1:0]   wd;     // write data, already lane placed
    logic                   we;     // write enable
    lsu_pkg::lsu_size_t     size;   // access size
    logic                   req;    // request level, held until ack
    logic                   ack;    // one-cycle acknowledge
    logic [`LSU_XLEN-1:0]   rd;     // read data, valid with ack

    modport issuer
    (
        output addr, wd, we, size, req,
        input  ack
    );

    modport memory
    (
        input  addr, wd, we, size, req,
        output ack, rd
    );

    // load formatting only looks at the response side
    modport reader
    (
        input  addr, size, ack, rd
    );

endinterface : dm_if

/* lsu_issue.sv */
// lsu request side
// checks alignment, places store bytes in their lanes and holds one
// data-memory request until the RAM acknowledges it

`timescale 1ns/1ns

`include "lsu_macros.svh"

module lsu_issue
(
    input  logic                    clk,
    input  logic                    resetn,
    input  lsu_pkg::dm_addr_t       result_imem,    // address from memory stage
    input  logic [`LSU_XLEN-1:0]    rd2_imem,       // store data
    input  logic                    we_dm_imem,     // store strobe
    input  logic                    rf_src_imem,    // load strobe
    input  logic                    sign_dm_imem,   // signed load
    input  lsu_pkg::lsu_size_t      size_dm_imem,   // access size
    input  logic                    stall_if,       // clears sticky error when low
    output logic                    lsu_busy,       // access in flight
    output logic                    lsu_err,        // misaligned access seen
    output logic                    s_misaligned,
    output logic                    l_misaligned,
    output logic                    sign_dm,        // latched sign for load align
    dm_if.issuer                    dm
);

    import lsu_pkg::*;

    logic                   access;     // load or store strobe
    logic                   misaligned;
    logic                   err_c;      // error this cycle
    logic                   err_ff;     // sticky part of lsu_err
    logic                   capture;    // launch a new access
    logic [`LSU_XLEN-1:0]   s_data;     // lane placed store data

    assign access     = we_dm_imem || rf_src_imem;
    assign misaligned = ((size_dm_imem == SIZE_WORD) && (result_imem[1:0] != 2'b00)) ||
                        ((size_dm_imem == SIZE_HALF) && result_imem[0]);

    assign s_misaligned = misaligned && we_dm_imem;
    assign l_misaligned = misaligned && rf_src_imem;
    assign err_c        = s_misaligned || l_misaligned;
    assign lsu_err      = err_c || err_ff;

    assign capture = access && !err_c && !lsu_busy;    // strobes while busy are dropped
    assign dm.req  = lsu_busy;

    // move the byte or halfword up to the lane its address selects
    always_comb
    begin
        case (size_dm_imem)
            SIZE_BYTE : s_data = rd2_imem << {result_imem[1:0], 3'b000};
            SIZE_HALF : s_data = rd2_imem << {result_imem[1], 4'b0000};
            default   : s_data = rd2_imem;
        endcase
    end

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            err_ff <= 1'b0;
        end
        else
        begin
            if (err_c)
                err_ff <= 1'b1;
            if (!stall_if)
                err_ff <= 1'b0;     // pipeline moved on, drop the error
        end
    end

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            lsu_busy <= 1'b0;
            dm.we    <= 1'b0;
        end
        else if (capture)
        begin
            lsu_busy <= 1'b1;
            dm.we    <= we_dm_imem;
        end
        else if (dm.ack)
        begin
            lsu_busy <= 1'b0;
        end
    end

    // request payload, held steady while req is high
    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            dm.addr <= result_imem;
            dm.wd   <= s_data;
            dm.size <= size_dm_imem;
            sign_dm <= sign_dm_imem;
        end
    end

endmodule : lsu_issue

/* data_ram.sv */
// data RAM
// word memory with byte lane writes and a fixed-latency ack pulse

`timescale 1ns/1ns

`include "lsu_macros.svh"

module data_ram
(
    input  logic    clk,
    input  logic    resetn,
    dm_if.memory    dm
);

    import lsu_pkg::*;

    localparam int IDX_W = $clog2(`LSU_DM_DEPTH);
    localparam int CNT_W = $clog2(`LSU_DM_LATENCY + 1);

    logic [`LSU_XLEN-1:0]   mem [`LSU_DM_DEPTH];
    logic [IDX_W-1:0]       idx;        // word index
    logic [3:0]             be;         // byte enables
    logic [CNT_W-1:0]       cnt;        // latency counter
    logic                   done;       // ack given, waiting for req low
    logic                   fire;       // last latency cycle

    assign idx  = dm.addr[IDX_W+1:2];
    assign fire = dm.req && !dm.ack && !done && (cnt == CNT_W'(`LSU_DM_LATENCY - 1));

    always_comb
    begin
        case (dm.size)
            SIZE_BYTE : be = 4'b0001 << dm.addr[1:0];
            SIZE_HALF : be = 4'b0011 << {dm.addr[1], 1'b0};
            default   : be = 4'b1111;
        endcase
    end

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            cnt  <= '0;
            ack_clear();
        end
        else
        begin
            dm.ack <= fire;
            if (fire)
            begin
                cnt  <= '0;
                done <= 1'b1;
            end
            else if (dm.req && !dm.ack && !done)
            begin
                cnt <= cnt + 1'b1;
            end
            if (!dm.req)
                done <= 1'b0;   // ready for the next request
        end
    end

    // lane writes and read word, both taken on the ack edge
    always_ff @(posedge clk)
    begin
        if (fire)
        begin
            dm.rd <= mem[idx];  // store sees the old word here
            if (dm.we)
            begin
                for (int i = 0; i < 4; i++)
                begin
                    if (be[i])
                        mem[idx][8*i +: 8] <= dm.wd[8*i +: 8];
                end
            end
        end
    end

    task automatic ack_clear();
        dm.ack <= 1'b0;
        done   <= 1'b0;
    endtask

endmodule : data_ram

/* lsu_load_align.sv */
// load formatting
// picks the addressed byte or halfword out of the read word, extends it
// and registers it for write-back

`timescale 1ns/1ns

`include "lsu_macros.svh"

module lsu_load_align
(
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    sign_dm,    // sign-extend short loads
    output logic [`LSU_XLEN-1:0]    rd_dm_iwb,  // value for write-back
    dm_if.reader                    dm
);

    import lsu_pkg::*;

    logic [`LSU_XLEN-1:0]   shifted;    // addressed data moved to lane 0
    logic [`LSU_XLEN-1:0]   l_data;     // extended load value

    always_comb
    begin
        case (dm.size)
            SIZE_BYTE : shifted = dm.rd >> {dm.addr[1:0], 3'b000};
            SIZE_HALF : shifted = dm.rd >> {dm.addr[1], 4'b0000};
            default   : shifted = dm.rd;
        endcase
    end

    always_comb
    begin
        case (dm.size)
            SIZE_BYTE : l_data = {{24{shifted[7] && sign_dm}}, shifted[7:0]};
            SIZE_HALF : l_data = {{16{shifted[15] && sign_dm}}, shifted[15:0]};
            default   : l_data = shifted;   // word passes through
        endcase
    end

    // updated on every ack, loads and stores alike
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
            rd_dm_iwb <= '0;
        else if (dm.ack)
            rd_dm_iwb <= l_data;
    end

endmodule : lsu_load_align

/* lsu_top.sv */
// load store unit top
// issue logic, data RAM and load formatting joined by the dm bus

`timescale 1ns/1ns

`include "lsu_macros.svh"

module lsu_top
(
    input  logic                    clk,
    input  logic                    resetn,
    input  lsu_pkg::dm_addr_t       result_imem,    // address from memory stage
    input  logic [`LSU_XLEN-1:0]    rd2_imem,       // store data
    input  logic                    we_dm_imem,     // store strobe
    input  logic                    rf_src_imem,    // load strobe
    input  logic                    sign_dm_imem,   // signed load
    input  lsu_pkg::lsu_size_t      size_dm_imem,   // access size
    input  logic                    stall_if,
    output logic [`LSU_XLEN-1:0]    rd_dm_iwb,      // load result
    output logic                    lsu_busy,
    output logic                    lsu_err,
    output logic                    s_misaligned,
    output logic                    l_misaligned
);

    logic sign_dm;  // latched sign, bypasses the RAM

    dm_if dm ();

    lsu_issue u_issue
    (
        .clk            (clk),
        .resetn         (resetn),
        .result_imem    (result_imem),
        .rd2_imem       (rd2_imem),
        .we_dm_imem     (we_dm_imem),
        .rf_src_imem    (rf_src_imem),
        .sign_dm_imem   (sign_dm_imem),
        .size_dm_imem   (size_dm_imem),
        .stall_if       (stall_if),
        .lsu_busy       (lsu_busy),
        .lsu_err        (lsu_err),
        .s_misaligned   (s_misaligned),
        .l_misaligned   (l_misaligned),
        .sign_dm        (sign_dm),
        .dm             (dm.issuer)
    );

    data_ram u_ram
    (
        .clk            (clk),
        .resetn         (resetn),
        .dm             (dm.memory)
    );

    lsu_load_align u_align
    (
        .clk            (clk),
        .resetn         (resetn),
        .sign_dm        (sign_dm),
        .rd_dm_iwb      (rd_dm_iwb),
        .dm             (dm.reader)
    );

endmodule : lsu_top

/* tb_lsu_top.sv */
// testbench for the load store unit
// random stores and loads checked against a byte shadow memory, load
// extension, access latency, misaligned accesses and the sticky error

`timescale 1ns/1ns

`include "lsu_macros.svh"

module tb_lsu_top;

    import lsu_pkg::*;

    localparam int TIMEOUT   = 50;                     // cycles allowed per access
    localparam int LAT_EDGES = `LSU_DM_LATENCY + 1;    // request edge to busy low

    logic           clk;
    logic           resetn;
    dm_addr_t       result_imem;
    logic [31:0]    rd2_imem;
    logic           we_dm_imem;
    logic           rf_src_imem;
    logic           sign_dm_imem;
    lsu_size_t      size_dm_imem;
    logic           stall_if;
    logic [31:0]    rd_dm_iwb;
    logic           lsu_busy;
    logic           lsu_err;
    logic           s_misaligned;
    logic           l_misaligned;

    logic [7:0]     shadow [0:255];     // model of RAM bytes 0..255
    integer         seed;
    int             errors;
    int             checks;
    logic           hung;               // an access never finished

    lsu_top dut
    (
        .clk            (clk),
        .resetn         (resetn),
        .result_imem    (result_imem),
        .rd2_imem       (rd2_imem),
        .we_dm_imem     (we_dm_imem),
        .rf_src_imem    (rf_src_imem),
        .sign_dm_imem   (sign_dm_imem),
        .size_dm_imem   (size_dm_imem),
        .stall_if       (stall_if),
        .rd_dm_iwb      (rd_dm_iwb),
        .lsu_busy       (lsu_busy),
        .lsu_err        (lsu_err),
        .s_misaligned   (s_misaligned),
        .l_misaligned   (l_misaligned)
    );

    always #10 clk = ~clk;

    // a misaligned strobe always shows up on lsu_err
    assert property (@(posedge clk) disable iff (!resetn)
        (s_misaligned || l_misaligned) |-> lsu_err)
    else
    begin
        $display("** Error at %0t ns: misaligned flag without lsu_err", $time);
        errors++;
    end

    // and it never starts an access
    assert property (@(posedge clk) disable iff (!resetn)
        (s_misaligned || l_misaligned) && !lsu_busy |=> !lsu_busy)
    else
    begin
        $display("** Error at %0t ns: misaligned access raised lsu_busy", $time);
        errors++;
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        assert (got === exp)
        else
        begin
            $display("** Error at %0t ns: %s is 0x%08h, expected 0x%08h",
                     $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        assert (got === exp)
        else
        begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_idle(input string when);
        check_flag(lsu_busy, 1'b0, {"lsu_busy ", when});
        check_flag(lsu_err, 1'b0, {"lsu_err ", when});
        check_flag(s_misaligned, 1'b0, {"s_misaligned ", when});
        check_flag(l_misaligned, 1'b0, {"l_misaligned ", when});
        check_value(rd_dm_iwb, 32'h0, {"rd_dm_iwb ", when});
    endtask

    // load result built from the shadow bytes
    function automatic logic [31:0] expected_load(input dm_addr_t addr, input lsu_size_t sz,
                                                  input logic sgn);
        logic [7:0]     b;
        logic [15:0]    h;
        logic [31:0]    w;
        b = shadow[addr[7:0]];
        h = {shadow[{addr[7:1], 1'b1}], shadow[{addr[7:1], 1'b0}]};
        w = {shadow[{addr[7:2], 2'd3}], shadow[{addr[7:2], 2'd2}],
             shadow[{addr[7:2], 2'd1}], shadow[{addr[7:2], 2'd0}]};
        case (sz)
            SIZE_BYTE : return sgn ? {{24{b[7]}}, b} : {24'd0, b};
            SIZE_HALF : return sgn ? {{16{h[15]}}, h} : {16'd0, h};
            default   : return w;
        endcase
    endfunction

    task automatic store_shadow(input dm_addr_t addr, input lsu_size_t sz,
                                input logic [31:0] data);
        int n;
        int k;
        n = (sz == SIZE_BYTE) ? 1 : (sz == SIZE_HALF) ? 2 : 4;
        for (k = 0; k < n; k++)
            shadow[addr[7:0] + 8'(k)] = data[8*k +: 8];    // low bytes of rd2
    endtask

    // one aligned access, optionally with a stray store strobe while busy
    task automatic run_access(input logic is_store, input lsu_size_t sz, input dm_addr_t addr,
                              input logic [31:0] data, input logic sgn, input logic intrude);
        int             edges;
        logic [31:0]    expected;
        string          what;
        what     = $sformatf("%s %s at 0x%08h", is_store ? "store" : "load", sz.name(), addr);
        expected = expected_load(addr, sz, sgn);
        @(posedge clk);
        result_imem  <= addr;
        rd2_imem     <= data;
        size_dm_imem <= sz;
        sign_dm_imem <= sgn;
        we_dm_imem   <= is_store;
        rf_src_imem  <= !is_store;
        @(posedge clk);     // request edge
        if (intrude)
        begin
            result_imem  <= {addr[31:2], 2'b00};
            rd2_imem     <= ~data;
            size_dm_imem <= SIZE_WORD;
            we_dm_imem   <= 1'b1;
            rf_src_imem  <= 1'b0;
        end
        else
        begin
            we_dm_imem  <= 1'b0;
            rf_src_imem <= 1'b0;
        end
        @(negedge clk);
        check_flag(lsu_busy, 1'b1, {what, ": busy after request edge"});
        edges = 0;
        while (lsu_busy && edges < TIMEOUT)
        begin
            @(posedge clk);
            we_dm_imem  <= 1'b0;
            rf_src_imem <= 1'b0;
            edges++;
            @(negedge clk);
        end
        if (lsu_busy)
        begin
            $display("timeout: %s was still busy after %0d cycles", what, TIMEOUT);
            errors++;
            hung = 1'b1;
        end
        else
        begin
            check_value(32'(edges), 32'(LAT_EDGES), {what, ": edges until busy falls"});
            if (is_store)
                store_shadow(addr, sz, data);
            else
                check_value(rd_dm_iwb, expected, {what, ": rd_dm_iwb"});
        end
    endtask

    // misaligned strobe with stall_if high, then release the stall
    task automatic misaligned_access(input logic is_store, input lsu_size_t sz,
                                     input dm_addr_t addr);
        int n;
        @(posedge clk);
        result_imem  <= addr;
        rd2_imem     <= $random(seed);
        size_dm_imem <= sz;
        we_dm_imem   <= is_store;
        rf_src_imem  <= !is_store;
        stall_if     <= 1'b1;
        @(negedge clk);
        check_flag(s_misaligned, is_store, "s_misaligned");
        check_flag(l_misaligned, !is_store, "l_misaligned");
        check_flag(lsu_err, 1'b1, "lsu_err with misaligned strobe");
        @(posedge clk);
        we_dm_imem  <= 1'b0;
        rf_src_imem <= 1'b0;
        for (n = 0; n < 3; n++)
        begin
            @(negedge clk);
            check_flag(lsu_err, 1'b1, "lsu_err held by stall_if");
            check_flag(lsu_busy, 1'b0, "lsu_busy after misaligned access");
            @(posedge clk);
        end
        stall_if <= 1'b0;
        @(posedge clk);     // first edge with stall_if low
        @(negedge clk);
        check_flag(lsu_err, 1'b0, "lsu_err one edge after stall_if low");
    endtask

    initial
    begin
        wait (hung);
        $display("checks: %0d  errors: %0d", checks, errors);
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        int             i;
        int             off;
        logic [31:0]    a;
        logic [31:0]    d;
        lsu_size_t      sz;
        seed         = 77;
        errors       = 0;
        checks       = 0;
        hung         = 1'b0;
        clk          = 1'b0;
        resetn       = 1'b0;
        result_imem  = '0;
        rd2_imem     = '0;
        we_dm_imem   = 1'b0;
        rf_src_imem  = 1'b0;
        sign_dm_imem = 1'b0;
        size_dm_imem = SIZE_WORD;
        stall_if     = 1'b0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        check_idle("during reset");
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        check_idle("after reset");

        // fill the test window so every load has known data
        for (i = 0; i < 64; i++)
            run_access(1'b1, SIZE_WORD, 32'(i * 4), $random(seed), 1'b0, 1'b0);

        for (i = 0; i < 24; i++)
        begin
            sz = lsu_size_t'(2'(i % 3));
            a  = $random(seed) & 32'hFF;
            d  = $random(seed);
            if (sz == SIZE_HALF)
                a[0] = 1'b0;
            if (sz == SIZE_WORD)
                a[1:0] = 2'b00;
            run_access(1'b1, sz, a, d, 1'b0, i % 4 == 1);
            run_access(1'b0, SIZE_WORD, {a[31:2], 2'b00}, '0, 1'b0, i % 4 == 3);
            if (i % 4 == 3)
                run_access(1'b0, SIZE_WORD, {a[31:2], 2'b00}, '0, 1'b0, 1'b0);  // no stray write
        end

        for (i = 0; i < 8; i++)
        begin
            a = $random(seed) & 32'hFC;
            if (i == 0)
                run_access(1'b1, SIZE_WORD, a, 32'hF08E_7F01, 1'b0, 1'b0);  // both signs
            for (off = 0; off < 4; off++)
            begin
                run_access(1'b0, SIZE_BYTE, a | 32'(off), '0, 1'b0, 1'b0);
                run_access(1'b0, SIZE_BYTE, a | 32'(off), '0, 1'b1, 1'b0);
            end
            for (off = 0; off < 4; off += 2)
            begin
                run_access(1'b0, SIZE_HALF, a | 32'(off), '0, 1'b0, 1'b0);
                run_access(1'b0, SIZE_HALF, a | 32'(off), '0, 1'b1, 1'b0);
            end
        end

        misaligned_access(1'b1, SIZE_WORD, 32'h0000_0011);
        misaligned_access(1'b0, SIZE_WORD, 32'h0000_0026);
        misaligned_access(1'b1, SIZE_HALF, 32'h0000_0033);
        misaligned_access(1'b0, SIZE_HALF, 32'h0000_0045);
        run_access(1'b0, SIZE_WORD, 32'h0000_0010, '0, 1'b0, 1'b0);
        run_access(1'b0, SIZE_WORD, 32'h0000_0024, '0, 1'b0, 1'b0);
        run_access(1'b0, SIZE_WORD, 32'h0000_0030, '0, 1'b0, 1'b0);
        run_access(1'b0, SIZE_WORD, 32'h0000_0044, '0, 1'b0, 1'b0);

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule : tb_lsu_top

/* sources.f */
+incdir+.
lsu_pkg.sv
dm_if.sv
lsu_issue.sv
data_ram.sv
lsu_load_align.sv
lsu_top.sv
tb_lsu_top.sv

/* run_sim.sh */
#!/bin/sh
# build the lsu testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_lsu_top -o tb_lsu_top \
    && ./obj_dir/tb_lsu_top | tee sim.log \
    || { echo "build or run failed"; exit 1; }

[ -f sim.log ] || { echo "no simulation log"; exit 1; }

grep -q "FAIL: see errors above" sim.log \
    && { echo "simulation failed"; exit 1; }

grep -q "PASS: all tests" sim.log \
    || { echo "simulation ended without a result"; exit 1; }

echo "simulation passed"
exit 0
